//--- src/rlight_pkg.sv
package rlight_pkg;

  // ------------------------------------------------------------------------
  // widths with a meaning
  // ------------------------------------------------------------------------

  typedef logic [7:0]  led_t;       // one bit per LED
  typedef logic [31:0] delay_t;     // step delay in clock cycles
  typedef logic [3:0]  reg_addr_t;  // byte address inside the block
  typedef logic [31:0] bus_data_t;  // bus data word

  // light modes, encoding as seen by software in MODE
  typedef enum logic [1:0] {
    MODE_PING_PONG = 2'd0,
    MODE_ROT_LEFT  = 2'd1,
    MODE_ROT_RIGHT = 2'd2,
    MODE_STOP      = 2'd3
  } rlight_mode_e;

  // ------------------------------------------------------------------------
  // bus structs
  // ------------------------------------------------------------------------

  typedef struct packed {
    reg_addr_t addr;   // byte address
    logic      we;     // 1 = write, 0 = read
    bus_data_t wdata;  // ignored on reads
  } reg_req_t;         // 37 bits

  typedef struct packed {
    bus_data_t rdata;  // zero on writes and errors
    logic      err;    // bad address or write to LED
  } reg_rsp_t;         // 33 bits

  // register block -> timer and engine
  typedef struct packed {
    led_t         pattern;
    rlight_mode_e mode;
    delay_t       delay;
    logic         pattern_we;  // one cycle, after a PATTERN write
    logic         delay_we;    // one cycle, after a DELAY write
  } rlight_cfg_t;

  // ------------------------------------------------------------------------
  // register map and reset values
  // ------------------------------------------------------------------------

  localparam reg_addr_t ADDR_PATTERN = 4'h0;
  localparam reg_addr_t ADDR_MODE    = 4'h4;
  localparam reg_addr_t ADDR_DELAY   = 4'h8;
  localparam reg_addr_t ADDR_LED     = 4'hC;  // read only

  localparam led_t         RST_PATTERN = 8'h3C;
  localparam rlight_mode_e RST_MODE    = MODE_PING_PONG;
  localparam delay_t       RST_DELAY   = 32'd100;

  // shifts per half sweep in ping-pong
  localparam int unsigned PP_STEPS = 7;

endpackage

//--- src/rlight_regs.sv
`timescale 1ns/1ps

module rlight_regs import rlight_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // request channel
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  reg_req_t    req_i,
  // response channel
  output logic        rsp_valid_o,
  input  logic        rsp_ready_i,
  output reg_rsp_t    rsp_o,
  // datapath side
  input  led_t        led_i,   // live LED state for LED reads
  output rlight_cfg_t cfg_o
);

  led_t         pattern_q;
  rlight_mode_e mode_q;
  delay_t       delay_q;
  logic         pattern_we_q;
  logic         delay_we_q;

  logic         busy_q;       // response being built, valid next cycle
  logic         rsp_valid_q;
  reg_rsp_t     rsp_q;        // held until taken
  reg_rsp_t     rsp_d;

  logic         accept;
  logic         wr_pattern;
  logic         wr_mode;
  logic         wr_delay;

  // ------------------------------------------------------------------------
  // handshake
  // ------------------------------------------------------------------------

  // free when nothing is pending or the pending response leaves now
  assign req_ready_o = !busy_q && (!rsp_valid_q || rsp_ready_i);
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      busy_q <= accept;            // only one request in flight
      if (busy_q) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;       // taken
      end
    end
  end

  // ------------------------------------------------------------------------
  // address decode and response data
  // ------------------------------------------------------------------------

  always_comb begin
    rsp_d      = '0;
    wr_pattern = 1'b0;
    wr_mode    = 1'b0;
    wr_delay   = 1'b0;
    case (req_i.addr)
      ADDR_PATTERN: begin
        rsp_d.rdata[7:0] = pattern_q;
        wr_pattern       = req_i.we;
      end
      ADDR_MODE: begin
        rsp_d.rdata[1:0] = mode_q;
        wr_mode          = req_i.we;
      end
      ADDR_DELAY: begin
        rsp_d.rdata = delay_q;
        wr_delay    = req_i.we;
      end
      ADDR_LED: begin
        rsp_d.rdata[7:0] = led_i;     // sampled at the accepting edge
        rsp_d.err        = req_i.we;  // read only
      end
      default: rsp_d.err = 1'b1;      // low address bits not zero
    endcase
    if (req_i.we || rsp_d.err) begin
      rsp_d.rdata = '0;  // no data on writes or errors
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q <= rsp_d;
    end
  end

  // ------------------------------------------------------------------------
  // registers and write strobes
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      pattern_q    <= RST_PATTERN;
      mode_q       <= RST_MODE;
      delay_q      <= RST_DELAY;
      pattern_we_q <= 1'b0;
      delay_we_q   <= 1'b0;
    end else begin
      if (accept && wr_pattern) pattern_q <= req_i.wdata[7:0];
      if (accept && wr_mode)    mode_q    <= rlight_mode_e'(req_i.wdata[1:0]);
      if (accept && wr_delay)   delay_q   <= req_i.wdata;
      // strobes line up with the new value
      pattern_we_q <= accept && wr_pattern;
      delay_we_q   <= accept && wr_delay;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  assign cfg_o.pattern    = pattern_q;
  assign cfg_o.mode       = mode_q;
  assign cfg_o.delay      = delay_q;
  assign cfg_o.pattern_we = pattern_we_q;
  assign cfg_o.delay_we   = delay_we_q;

endmodule

//--- src/rlight_step_timer.sv
`timescale 1ns/1ps

// paces the light with one step pulse every delay_i+1 cycles
module rlight_step_timer import rlight_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  delay_t delay_i,   // reload value
  input  logic   reload_i,  // restart from delay_i
  output logic   step_o     // high while the count is zero
);

  delay_t cnt_q;
  logic   cnt_zero;

  // ------------------------------------------------------------------------
  // down-counter
  // ------------------------------------------------------------------------

  assign cnt_zero = (cnt_q == '0);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= RST_DELAY;         // same as the DELAY register
    end else if (reload_i || cnt_zero) begin
      cnt_q <= delay_i;           // restart on a DELAY write or wrap with the step
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // delay 0 keeps the count at zero and steps every cycle
  assign step_o = cnt_zero;

endmodule

//--- src/rlight_engine.sv
`timescale 1ns/1ps

module rlight_engine import rlight_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  rlight_mode_e mode_i,
  input  led_t         pattern_i,  // stable while load_i travels
  input  logic         load_i,     // PATTERN write strobe
  input  logic         step_i,     // from the step timer
  output led_t         led_o
);

  // ping-pong half sweep
  typedef enum logic {
    SWEEP_LEFT  = 1'b0,
    SWEEP_RIGHT = 1'b1
  } sweep_e;

  led_t       led_q;
  led_t       shadow_q;   // bits pushed out on the left
  sweep_e     sweep_q;
  logic [2:0] pp_cnt_q;   // shifts done in this half
  logic       load_q;     // load lands one cycle after the strobe

  led_t       led_d;
  led_t       shadow_d;
  sweep_e     sweep_d;
  logic [2:0] pp_cnt_d;
  logic       pp_last;

  assign pp_last = (pp_cnt_q == 3'(PP_STEPS - 1));

  // ------------------------------------------------------------------------
  // next step
  // ------------------------------------------------------------------------

  always_comb begin
    led_d    = led_q;
    shadow_d = shadow_q;
    sweep_d  = sweep_q;
    pp_cnt_d = pp_cnt_q;
    if (load_q) begin
      led_d    = pattern_i;
      shadow_d = '0;
      sweep_d  = SWEEP_LEFT;
      pp_cnt_d = '0;
    end else if (step_i) begin
      case (mode_i)
        MODE_ROT_LEFT:  led_d = {led_q[6:0], led_q[7]};  // msb wraps to bit 0
        MODE_ROT_RIGHT: led_d = {led_q[0], led_q[7:1]};  // lsb wraps to bit 7
        MODE_PING_PONG: begin
          if (sweep_q == SWEEP_LEFT) begin
            led_d    = {led_q[6:0], 1'b0};        // zero fill
            shadow_d = {shadow_q[6:0], led_q[7]}; // keep what falls off
          end else begin
            led_d    = {shadow_q[0], led_q[7:1]}; // bring it back
            shadow_d = {1'b0, shadow_q[7:1]};
          end
          if (pp_last) begin
            pp_cnt_d = '0;
            sweep_d  = (sweep_q == SWEEP_LEFT) ? SWEEP_RIGHT : SWEEP_LEFT;
          end else begin
            pp_cnt_d = pp_cnt_q + 3'd1;
          end
        end
        default: ;  // stop, hold
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // state
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      led_q    <= RST_PATTERN;
      shadow_q <= '0;
      sweep_q  <= SWEEP_LEFT;
      pp_cnt_q <= '0;
      load_q   <= 1'b0;
    end else begin
      led_q    <= led_d;
      shadow_q <= shadow_d;
      sweep_q  <= sweep_d;
      pp_cnt_q <= pp_cnt_d;
      load_q   <= load_i;
    end
  end

  assign led_o = led_q;

endmodule

//--- src/rlight_top.sv
`timescale 1ns/1ps

module rlight_top import rlight_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // register bus
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  reg_req_t req_i,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output reg_rsp_t rsp_o,
  // lights
  output led_t     led_o
);

  rlight_cfg_t cfg;
  logic        step;
  led_t        led;   // live LED state, also read back

  // ------------------------------------------------------------------------
  // register block
  // ------------------------------------------------------------------------

  rlight_regs i_regs (
    .clk_i,
    .rst_ni,
    .req_valid_i,
    .req_ready_o,
    .req_i,
    .rsp_valid_o,
    .rsp_ready_i,
    .rsp_o,
    .led_i (led),
    .cfg_o (cfg)
  );

  // ------------------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------------------

  rlight_step_timer i_timer (
    .clk_i,
    .rst_ni,
    .delay_i  (cfg.delay),
    .reload_i (cfg.delay_we),  // restart on every DELAY write
    .step_o   (step)
  );

  rlight_engine i_engine (
    .clk_i,
    .rst_ni,
    .mode_i    (cfg.mode),
    .pattern_i (cfg.pattern),
    .load_i    (cfg.pattern_we),
    .step_i    (step),
    .led_o     (led)
  );

  assign led_o = led;

endmodule

//--- dv/rlight_tb.sv
`timescale 1ns/1ps

module rlight_tb import rlight_pkg::*; ();

  localparam int unsigned TIMEOUT = 4000;  // all tests at DELAY <= 7 plus margin

  logic        clk_i;
  logic        rst_ni;
  logic        req_valid_i;
  logic        req_ready_o;
  reg_req_t    req_i;
  logic        rsp_valid_o;
  logic        rsp_ready_i;
  reg_rsp_t    rsp_o;
  led_t        led_o;

  int unsigned cyc = 0;          // edges since time 0
  int          err_cnt = 0;
  int          n_tests = 0;
  int          n_fail = 0;
  int          test_err0;
  string       cur_test = "reset";
  int unsigned spacing_exp = 0;  // expected cycles between LED changes or 0 when off
  reg_rsp_t    rsp;
  int unsigned acc;              // cycle of the accepting edge
  led_t        pat;
  led_t        pp_pat;
  led_t        snap;

  rlight_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  // ------------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------------

  function automatic led_t rotl8(led_t v);
    return led_t'((v << 1) | (v >> 7));
  endfunction

  function automatic led_t rotr8(led_t v);
    return led_t'((v >> 1) | (v << 7));
  endfunction

  // k-th change of a sweep from 1 to 14
  // left half zero fills and the right half undoes it
  function automatic led_t pp_expect(led_t p, int k);
    int sh;
    sh = (k <= PP_STEPS) ? k : 2 * PP_STEPS - k;
    return led_t'(p << sh);
  endfunction

  // lsb set so no shift or rotation leaves the LEDs unchanged
  function automatic led_t random_pattern();
    led_t p;
    p = led_t'($urandom) | 8'h01;
    while (rotl8(p) == p) p = led_t'($urandom) | 8'h01;
    return p;
  endfunction

  // ------------------------------------------------------------------------
  // bus and check tasks
  // ------------------------------------------------------------------------

  task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %s %s expected %0h actual %0h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  // one request with the response held back for stall cycles
  task automatic transfer(input reg_addr_t addr, input logic we, input bus_data_t wdata,
                          input int stall, output reg_rsp_t r, output int unsigned a);
    req_valid_i <= 1'b1;
    req_i       <= {addr, we, wdata};
    rsp_ready_i <= (stall == 0);
    do @(posedge clk_i); while (!req_ready_o);
    a = cyc;
    req_valid_i <= 1'b0;
    do @(posedge clk_i); while (!rsp_valid_o);
    if (stall > 0) begin
      repeat (stall) @(posedge clk_i);
      rsp_ready_i <= 1'b1;
      @(posedge clk_i);             // taken here
    end
    r = rsp_o;
  endtask

  task automatic bus_write(input reg_addr_t addr, input bus_data_t data, input int stall,
                           output reg_rsp_t r, output int unsigned a);
    transfer(addr, 1'b1, data, stall, r, a);
  endtask

  task automatic bus_read(input reg_addr_t addr, input int stall, output reg_rsp_t r);
    int unsigned a;
    transfer(addr, 1'b0, '0, stall, r, a);
  endtask

  task automatic write_reg(reg_addr_t addr, bus_data_t data);
    bus_write(addr, data, 0, rsp, acc);
    check_value("write err", 0, rsp.err);
  endtask

  task automatic expect_read(reg_addr_t addr, bus_data_t exp, string what);
    bus_read(addr, 0, rsp);
    check_value({what, " read"}, exp, rsp.rdata);
    check_value({what, " err"}, 0, rsp.err);
  endtask

  task automatic next_led(input led_t prev, output led_t now);
    do @(posedge clk_i); while (led_o === prev);
    now = led_o;
  endtask

  task automatic follow_rotation(int n, logic left);
    led_t prev;
    led_t cur;
    cur = led_o;
    repeat (n) begin
      prev = cur;
      next_led(prev, cur);
      check_value("rotation step", left ? rotl8(prev) : rotr8(prev), cur);
    end
  endtask

  task automatic start_test(string name);
    cur_test  = name;
    test_err0 = err_cnt;
  endtask

  task automatic end_test();
    n_tests++;
    if (err_cnt == test_err0) begin
      $display("test %s: ok", cur_test);
    end else begin
      n_fail++;
      $display("test %s: %0d error(s)", cur_test, err_cnt - test_err0);
    end
  endtask

  // ------------------------------------------------------------------------
  // monitors
  // ------------------------------------------------------------------------

  led_t        led_prev;
  int unsigned gap;         // edges since the last LED change
  logic        gap_armed;   // first change after enabling only starts the count
  logic        led_rd_pend; // LED read in flight
  led_t        led_rd_val;  // led_o at its accepting edge

  always @(posedge clk_i) begin
    led_prev <= led_o;
    if (spacing_exp == 0) begin
      gap_armed <= 1'b0;
    end else if (led_o !== led_prev) begin
      a_spacing: assert (!gap_armed || gap == spacing_exp) else begin
        $display("FAILED %s step spacing expected %0d actual %0d", cur_test, spacing_exp, gap);
        err_cnt++;
      end
      gap       <= 1;
      gap_armed <= 1'b1;
    end else begin
      gap <= gap + 1;
    end
  end

  always @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      led_rd_pend <= 1'b0;
    end else begin
      if (rsp_valid_o && rsp_ready_i) led_rd_pend <= 1'b0;
      if (req_valid_i && req_ready_o && req_i.addr == ADDR_LED && !req_i.we) begin
        led_rd_pend <= 1'b1;
        led_rd_val  <= led_o;
      end
    end
  end

  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i))
    else begin
      $display("%s: request dropped or changed before it was accepted", cur_test);
      err_cnt++;
    end

  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else begin
      $display("%s: response dropped or changed while the master stalled", cur_test);
      err_cnt++;
    end

  a_stall_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |-> !req_ready_o)
    else begin
      $display("%s: new request allowed while a response was pending", cur_test);
      err_cnt++;
    end

  a_led_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && rsp_ready_i && led_rd_pend |-> rsp_o.rdata == {24'h0, led_rd_val})
    else begin
      $display("FAILED %s LED readback expected %0h actual %0h", cur_test,
               $sampled(led_rd_val), $sampled(rsp_o.rdata));
      err_cnt++;
    end

  // ------------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------------

  initial begin
    void'($urandom(32'hebb3_1220));
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    start_test("reset values");
    check_value("led_o", 8'h3C, led_o);
    check_value("req_ready_o", 1, req_ready_o);
    check_value("rsp_valid_o", 0, rsp_valid_o);
    expect_read(ADDR_PATTERN, 32'h3C, "PATTERN");
    expect_read(ADDR_MODE, 32'h0, "MODE");
    expect_read(ADDR_DELAY, 32'd100, "DELAY");
    expect_read(ADDR_LED, 32'h3C, "LED");
    end_test();

    start_test("rotate left");
    write_reg(ADDR_MODE, MODE_STOP);   // freeze while loading
    write_reg(ADDR_DELAY, 32'd3);
    pat = random_pattern();
    snap = led_o;
    bus_write(ADDR_PATTERN, pat, 0, rsp, acc);
    while (cyc < acc + 2) @(posedge clk_i);
    check_value("pattern too early", snap, led_o);  // old value until the second edge
    while (cyc < acc + 3) @(posedge clk_i);  // two edges after the accepting one
    check_value("pattern load", pat, led_o);
    write_reg(ADDR_MODE, MODE_ROT_LEFT);
    spacing_exp <= 4;
    follow_rotation(20, 1'b1);
    spacing_exp <= 0;
    end_test();

    start_test("rotate right");
    write_reg(ADDR_MODE, MODE_STOP);
    write_reg(ADDR_DELAY, 32'd0);      // step every cycle
    write_reg(ADDR_PATTERN, random_pattern());
    write_reg(ADDR_MODE, MODE_ROT_RIGHT);
    spacing_exp <= 1;
    follow_rotation(20, 1'b0);
    spacing_exp <= 0;
    write_reg(ADDR_DELAY, 32'd5);      // reloads the timer
    spacing_exp <= 6;
    follow_rotation(10, 1'b0);
    spacing_exp <= 0;
    end_test();

    start_test("ping-pong");
    write_reg(ADDR_MODE, MODE_STOP);
    write_reg(ADDR_DELAY, 32'd2);
    pp_pat = random_pattern();
    write_reg(ADDR_PATTERN, pp_pat);
    write_reg(ADDR_MODE, MODE_PING_PONG);
    snap = pp_pat;
    for (int k = 1; k <= 2 * PP_STEPS; k++) begin
      next_led(snap, snap);
      check_value("ping-pong step", pp_expect(pp_pat, k), snap);
    end
    end_test();

    start_test("stop and readback");
    write_reg(ADDR_MODE, MODE_STOP);
    snap = led_o;
    repeat (50) begin
      @(posedge clk_i);
      check_value("held LED", snap, led_o);
    end
    expect_read(ADDR_LED, snap, "LED");
    end_test();

    start_test("errors and back-pressure");
    bus_write(ADDR_LED, 32'hFF, 0, rsp, acc);
    check_value("LED write err", 1, rsp.err);
    bus_write(4'h1, 32'h12, 0, rsp, acc);
    check_value("misaligned write err", 1, rsp.err);
    bus_read(4'h6, 0, rsp);
    check_value("misaligned read err", 1, rsp.err);
    check_value("misaligned read data", 0, rsp.rdata);
    expect_read(ADDR_PATTERN, pp_pat, "PATTERN");
    expect_read(ADDR_MODE, MODE_STOP, "MODE");
    expect_read(ADDR_DELAY, 32'd2, "DELAY");
    expect_read(ADDR_LED, snap, "LED");
    fork
      bus_read(ADDR_DELAY, int'($urandom % 16) + 1, rsp);
      begin  // second read waits behind the held response
        repeat (2) @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_i       <= {ADDR_MODE, 1'b0, 32'h0};
        do @(posedge clk_i); while (!req_ready_o);
        req_valid_i <= 1'b0;
        do @(posedge clk_i); while (!rsp_valid_o);
        check_value("queued MODE read", MODE_STOP, rsp_o.rdata);
      end
    join
    check_value("stalled DELAY read", 32'd2, rsp.rdata);
    pat = random_pattern();
    bus_write(ADDR_PATTERN, pat, int'($urandom % 16) + 1, rsp, acc);
    check_value("stalled write err", 0, rsp.err);
    expect_read(ADDR_PATTERN, pat, "PATTERN");
    end_test();

    $display("tests: %0d run, %0d passed, %0d failed, %0d errors",
             n_tests, n_tests - n_fail, n_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    wait (cyc >= TIMEOUT);
    $display("run stopped after %0d cycles, test %s did not finish", TIMEOUT, cur_test);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- compile.f
src/rlight_pkg.sv
src/rlight_regs.sv
src/rlight_step_timer.sv
src/rlight_engine.sv
src/rlight_top.sv
dv/rlight_tb.sv

//--- Makefile
TOOL  ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal -j 0
TOP   ?= rlight_tb
FLIST ?= compile.f
BUILD ?= obj_dir
LOG   ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing run"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
